/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_port_arbiter
FILELIST  ?= port_arbiter.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* port_arbiter.f */
source/arb_pkg.sv
source/poll_decode.sv
source/grant_execute.sv
source/result_register.sv
source/port_arbiter.sv
verification/tb_port_arbiter.sv

/* source/arb_pkg.sv */
`default_nettype none

package arb_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int port_id_w  = 4;  // 16 ports
	localparam int que_info_w = 30; // addr_start 14, len 12, pri 4
	localparam int rd_info_w  = 28;

	////////////////////////////////////////
	// vector types
	////////////////////////////////////////

	typedef logic [port_id_w-1:0] port_id_t;

	typedef logic [que_info_w-1:0] que_info_t;

	// port index on top of the ingress descriptor
	typedef logic [port_id_w+que_info_w-1:0] tagged_que_t;

	typedef logic [rd_info_w-1:0] rd_info_t;

	// [4] direction, 0 write 1 read; [3:0] port
	typedef logic [port_id_w:0] ctrl_flag_t;

	////////////////////////////////////////
	// poll sequencer phases
	////////////////////////////////////////

	typedef enum logic [1:0]
	{
		phase_poll  = 2'd0, // test one request bit
		phase_latch = 2'd1, // capture flag
		phase_hold  = 2'd2  // grant up until update done
	} poll_phase_t;

endpackage

`default_nettype wire

/* source/grant_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module grant_execute
#(
	parameter int num_ports = 16
)
(
	input  arb_pkg::port_id_t                    cur_port,
	input  wire logic                            hold_wr,
	input  wire logic                            hold_rd,
	input  arb_pkg::que_info_t [num_ports-1:0]   port_que_info,
	input  arb_pkg::rd_info_t  [num_ports-1:0]   port_rd_info_in,
	output logic               [num_ports-1:0]   wr_req_done,
	output logic               [num_ports-1:0]   rd_req_done,
	output arb_pkg::tagged_que_t                 que_sel,
	output arb_pkg::rd_info_t                    rd_sel
);

	logic [num_ports-1:0] port_onehot;

	////////////////////////////////////////
	// grant decode
	////////////////////////////////////////

	// single bit walked up to the served port
	assign port_onehot = {{(num_ports - 1){1'b0}}, 1'b1} << cur_port;

	always_comb
	begin
		wr_req_done = '0;
		rd_req_done = '0;
		if (hold_wr)
			wr_req_done = port_onehot;
		if (hold_rd)
			rd_req_done = port_onehot;
	end

	////////////////////////////////////////
	// descriptor select
	////////////////////////////////////////

	assign que_sel = {cur_port, port_que_info[cur_port]}; // port tag above descriptor
	assign rd_sel  = port_rd_info_in[cur_port];

endmodule

`default_nettype wire

/* source/poll_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module poll_decode
#(
	parameter int num_ports = 16
)
(
	input  wire logic                 sys_clk,
	input  wire logic                 sys_rst,
	input  wire logic [num_ports-1:0] wr_req_addr,
	input  wire logic [num_ports-1:0] rd_req_addr,
	input  wire logic                 port_wr_re,
	input  wire logic                 port_rd_re,
	output arb_pkg::port_id_t         cur_port,
	output logic                      cur_dir,
	output logic                      latch,
	output logic                      hold_wr,
	output logic                      hold_rd
);

	import arb_pkg::*;

	poll_phase_t phase;

	logic req_bit;   // request of the polled port
	logic done;      // update done for active direction
	logic last_port;
	logic step;      // move on to the next port

	assign req_bit   = cur_dir ? rd_req_addr[cur_port] : wr_req_addr[cur_port];
	assign done      = cur_dir ? port_rd_re : port_wr_re;
	assign last_port = (cur_port == port_id_t'(num_ports - 1));

	assign step = ((phase == phase_poll) && !req_bit) ||
		((phase == phase_hold) && done);

	////////////////////////////////////////
	// phase register
	////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (sys_rst)
			phase <= phase_poll;
		else
		begin
			case (phase)
				phase_poll:
				begin
					if (req_bit)
						phase <= phase_latch;
				end
				phase_latch:
					phase <= phase_hold;
				phase_hold:
				begin
					if (done)
						phase <= phase_poll;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// port counter and direction
	////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (sys_rst)
		begin
			cur_port <= '0;
			cur_dir  <= 1'b0; // write side first
		end
		else if (step)
		begin
			if (last_port)
			begin
				cur_port <= '0;
				cur_dir  <= ~cur_dir; // write -> read -> write
			end
			else
				cur_port <= cur_port + 1'b1;
		end
	end

	assign latch   = (phase == phase_latch);
	assign hold_wr = (phase == phase_hold) && !cur_dir;
	assign hold_rd = (phase == phase_hold) && cur_dir;

endmodule

`default_nettype wire

/* source/port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
#(
	parameter int num_ports = 16
)
(
	input  wire logic                            sys_clk,
	input  wire logic                            sys_rst,
	input  wire logic          [num_ports-1:0]   wr_req_addr,
	input  wire logic          [num_ports-1:0]   rd_req_addr,
	input  wire logic                            port_wr_re,
	input  wire logic                            port_rd_re,
	input  arb_pkg::que_info_t [num_ports-1:0]   port_que_info,
	input  arb_pkg::rd_info_t  [num_ports-1:0]   port_rd_info_in,
	output logic               [num_ports-1:0]   wr_req_done,
	output logic               [num_ports-1:0]   rd_req_done,
	output arb_pkg::tagged_que_t                 port_que_info_out,
	output arb_pkg::rd_info_t                    port_rd_info,
	output arb_pkg::ctrl_flag_t                  ctrl_flag
);

	import arb_pkg::*;

	port_id_t    cur_port;
	logic        cur_dir;
	logic        latch;
	logic        hold_wr;
	logic        hold_rd;
	tagged_que_t que_sel;
	rd_info_t    rd_sel;

	////////////////////////////////////////
	// poll, grant, register
	////////////////////////////////////////

	poll_decode #(
		.num_ports (num_ports)
	) u_poll_decode (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.wr_req_addr (wr_req_addr),
		.rd_req_addr (rd_req_addr),
		.port_wr_re  (port_wr_re),
		.port_rd_re  (port_rd_re),
		.cur_port    (cur_port),
		.cur_dir     (cur_dir),
		.latch       (latch),
		.hold_wr     (hold_wr),
		.hold_rd     (hold_rd)
	);

	grant_execute #(
		.num_ports (num_ports)
	) u_grant_execute (
		.cur_port        (cur_port),
		.hold_wr         (hold_wr),
		.hold_rd         (hold_rd),
		.port_que_info   (port_que_info),
		.port_rd_info_in (port_rd_info_in),
		.wr_req_done     (wr_req_done),
		.rd_req_done     (rd_req_done),
		.que_sel         (que_sel),
		.rd_sel          (rd_sel)
	);

	result_register u_result_register (
		.sys_clk           (sys_clk),
		.sys_rst           (sys_rst),
		.latch             (latch),
		.hold_wr           (hold_wr),
		.hold_rd           (hold_rd),
		.cur_port          (cur_port),
		.cur_dir           (cur_dir),
		.que_sel           (que_sel),
		.rd_sel            (rd_sel),
		.port_que_info_out (port_que_info_out),
		.port_rd_info      (port_rd_info),
		.ctrl_flag         (ctrl_flag)
	);

endmodule

`default_nettype wire

/* source/result_register.sv */
`timescale 1ns/1ps
`default_nettype none

module result_register
(
	input  wire logic           sys_clk,
	input  wire logic           sys_rst,
	input  wire logic           latch,
	input  wire logic           hold_wr,
	input  wire logic           hold_rd,
	input  arb_pkg::port_id_t   cur_port,
	input  wire logic           cur_dir,
	input  arb_pkg::tagged_que_t que_sel,
	input  arb_pkg::rd_info_t   rd_sel,
	output arb_pkg::tagged_que_t port_que_info_out,
	output arb_pkg::rd_info_t   port_rd_info,
	output arb_pkg::ctrl_flag_t ctrl_flag
);

	// direction and port of the access in progress
	always_ff @(posedge sys_clk)
	begin
		if (sys_rst)
			ctrl_flag <= '0;
		else if (latch)
			ctrl_flag <= {cur_dir, cur_port};
	end

	////////////////////////////////////////
	// arbitration results to memory ctrl
	////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (sys_rst)
			port_que_info_out <= '0;
		else if (hold_wr)
			port_que_info_out <= que_sel; // reloads every hold cycle
	end

	always_ff @(posedge sys_clk)
	begin
		if (sys_rst)
			port_rd_info <= '0;
		else if (hold_rd)
			port_rd_info <= rd_sel;
	end

endmodule

`default_nettype wire

/* verification/tb_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_port_arbiter;

	import arb_pkg::*;

	localparam int num_ports    = 16;
	localparam int pos_w        = $clog2(num_ports) + 1;
	localparam int round_cycles = 2 * num_ports;
	localparam int serve_max    = 20; // poll, latch, longest delay, strobes
	localparam int rr_rounds    = 2;
	localparam int test_cycles  = 8 + 2 * round_cycles + 4 * (round_cycles + serve_max) +
		rr_rounds * (2 * round_cycles + 2 * num_ports * serve_max);
	localparam logic [pos_w-1:0] last_pos = '1; // last read port

	typedef logic [num_ports-1:0] req_vec_t;
	typedef enum logic [1:0] {mp_poll, mp_latch, mp_hold} model_phase_t;

	logic                      sys_clk;
	logic                      sys_rst;
	req_vec_t                  wr_req_addr;
	req_vec_t                  rd_req_addr;
	logic                      port_wr_re;
	logic                      port_rd_re;
	que_info_t [num_ports-1:0] port_que_info;
	rd_info_t  [num_ports-1:0] port_rd_info_in;
	req_vec_t                  wr_req_done;
	req_vec_t                  rd_req_done;
	tagged_que_t               port_que_info_out;
	rd_info_t                  port_rd_info;
	ctrl_flag_t                ctrl_flag;

	logic [pos_w-1:0] m_pos; // direction on top of port
	model_phase_t     m_phase;
	ctrl_flag_t       m_flag;
	tagged_que_t      m_que;
	rd_info_t         m_rd;
	logic             m_dir;
	port_id_t         m_port;
	logic             m_req;
	logic             m_done;
	logic             any_grant;
	logic             grant_q;
	req_vec_t         exp_wr;
	req_vec_t         exp_rd;

	logic [15:0] lfsr;
	string       test_name;
	int          err_count;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          grants_seen;

	port_arbiter #(
		.num_ports (num_ports)
	) u_dut (
		.sys_clk           (sys_clk),
		.sys_rst           (sys_rst),
		.wr_req_addr       (wr_req_addr),
		.rd_req_addr       (rd_req_addr),
		.port_wr_re        (port_wr_re),
		.port_rd_re        (port_rd_re),
		.port_que_info     (port_que_info),
		.port_rd_info_in   (port_rd_info_in),
		.wr_req_done       (wr_req_done),
		.rd_req_done       (rd_req_done),
		.port_que_info_out (port_que_info_out),
		.port_rd_info      (port_rd_info),
		.ctrl_flag         (ctrl_flag)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	initial
	begin
		repeat (2 * test_cycles) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, run did not finish", 2 * test_cycles);
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	assign m_dir     = m_pos[pos_w-1];
	assign m_port    = m_pos[pos_w-2:0];
	assign m_req     = m_dir ? rd_req_addr[m_port] : wr_req_addr[m_port];
	assign m_done    = m_dir ? port_rd_re : port_wr_re;
	assign any_grant = |{wr_req_done, rd_req_done};

	always @(posedge sys_clk)
	begin
		if (sys_rst)
		begin
			m_pos   <= '0;
			m_phase <= mp_poll;
			m_flag  <= '0;
			m_que   <= '0;
			m_rd    <= '0;
		end
		else
		begin
			case (m_phase)
				mp_poll:
				begin
					if (m_req)
						m_phase <= mp_latch;
					else
						m_pos <= m_pos + 1'b1; // last read port wraps to write port 0
				end
				mp_latch:
				begin
					m_phase <= mp_hold;
					m_flag  <= {m_dir, m_port};
				end
				default:
				begin
					if (m_dir)
						m_rd <= port_rd_info_in[m_port];
					else
						m_que <= {m_port, port_que_info[m_port]};
					if (m_done)
					begin
						m_phase <= mp_poll;
						m_pos   <= m_pos + 1'b1;
					end
				end
			endcase
		end
	end

	task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp)
		else
		begin
			$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
			err_count++;
		end
	endtask

	// every cycle against the model
	always @(negedge sys_clk)
	begin
		if (sys_rst !== 1'b0)
			grant_q = 1'b0;
		else
		begin
			exp_wr = '0;
			exp_rd = '0;
			if (m_phase == mp_hold && m_dir)
				exp_rd[m_port] = 1'b1;
			if (m_phase == mp_hold && !m_dir)
				exp_wr[m_port] = 1'b1;
			check_val("wr_req_done", exp_wr, wr_req_done);
			check_val("rd_req_done", exp_rd, rd_req_done);
			check_val("ctrl_flag", m_flag, ctrl_flag);
			check_val("port_que_info_out", m_que, port_que_info_out);
			check_val("port_rd_info", m_rd, port_rd_info);
			assert ($onehot0({wr_req_done, rd_req_done}))
			else
			begin
				$display("%s: more than one grant is high at once", test_name);
				err_count++;
			end
			if (any_grant && !grant_q)
				grants_seen++;
			grant_q = any_grant;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr); // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		test_errs = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count == test_errs)
			$display("%s: passed", test_name);
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, err_count - test_errs);
		end
	endtask

	task automatic load_descriptors();
		@(posedge sys_clk);
		for (int i = 0; i < num_ports; i++)
		begin
			port_que_info[i]   <= que_info_t'(rand_bits(que_info_w));
			port_rd_info_in[i] <= rd_info_t'(rand_bits(rd_info_w));
		end
	endtask

	task automatic wait_grant();
		@(negedge sys_clk);
		while (!any_grant)
			@(negedge sys_clk);
	endtask

	// wait until the last read port is polled
	task automatic align_round();
		@(negedge sys_clk);
		while (!(m_pos == last_pos && m_phase == mp_poll))
			@(negedge sys_clk);
	endtask

	// called in a hold cycle, returns at the first cycle after it
	task automatic serve_hold(input int delay, input logic wrong_strobe);
		logic dir;
		dir = |rd_req_done;
		repeat (delay) @(posedge sys_clk);
		if (wrong_strobe)
		begin
			@(posedge sys_clk);
			if (dir)
				port_wr_re <= 1'b1;
			else
				port_rd_re <= 1'b1;
			@(posedge sys_clk);
			port_wr_re <= 1'b0;
			port_rd_re <= 1'b0;
		end
		@(posedge sys_clk);
		if (dir)
			port_rd_re <= 1'b1;
		else
			port_wr_re <= 1'b1;
		@(posedge sys_clk);
		port_wr_re <= 1'b0;
		port_rd_re <= 1'b0;
		@(negedge sys_clk);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	initial
	begin
		port_id_t    k;
		req_vec_t    pat_wr;
		req_vec_t    pat_rd;
		tagged_que_t que_prev;
		int          grants0;

		lfsr            = 16'd97;
		err_count       = 0;
		tests_run       = 0;
		tests_failed    = 0;
		grants_seen     = 0;
		test_name       = "reset";
		sys_rst         = 1'b1;
		wr_req_addr     = '0;
		rd_req_addr     = '0;
		port_wr_re      = 1'b0;
		port_rd_re      = 1'b0;
		port_que_info   = '0;
		port_rd_info_in = '0;
		repeat (8) @(posedge sys_clk);
		sys_rst <= 1'b0;

		start_test("reset_idle");
		@(negedge sys_clk);
		check_val("grants", '0, {wr_req_done, rd_req_done});
		check_val("port_que_info_out", '0, port_que_info_out);
		check_val("port_rd_info", '0, port_rd_info);
		check_val("ctrl_flag", '0, ctrl_flag);
		@(posedge sys_clk);
		grants0 = grants_seen;
		repeat (2 * round_cycles) @(posedge sys_clk);
		check_val("grant_count", 0, grants_seen - grants0);
		end_test();

		start_test("single_write");
		load_descriptors();
		k = port_id_t'(rand_bits(port_id_w));
		@(posedge sys_clk);
		wr_req_addr[k] <= 1'b1;
		wait_grant();
		check_val("wr_req_done", req_vec_t'(1) << k, wr_req_done);
		check_val("ctrl_flag", {1'b0, k}, ctrl_flag);
		@(negedge sys_clk);
		check_val("port_que_info_out", {k, port_que_info[k]}, port_que_info_out);
		que_prev = {k, port_que_info[k]}; // stays through the read test
		serve_hold(int'(rand_bits(3)), 1'b0);
		check_val("grant_after_done", '0, wr_req_done);
		@(posedge sys_clk);
		wr_req_addr <= '0;
		end_test();

		start_test("single_read");
		load_descriptors();
		k = port_id_t'(rand_bits(port_id_w));
		@(posedge sys_clk);
		rd_req_addr[k] <= 1'b1;
		wait_grant();
		check_val("rd_req_done", req_vec_t'(1) << k, rd_req_done);
		check_val("ctrl_flag", {1'b1, k}, ctrl_flag);
		@(negedge sys_clk);
		check_val("port_rd_info", port_rd_info_in[k], port_rd_info);
		check_val("port_que_info_out", que_prev, port_que_info_out);
		serve_hold(int'(rand_bits(3)), 1'b0);
		check_val("grant_after_done", '0, rd_req_done);
		@(posedge sys_clk);
		rd_req_addr <= '0;
		end_test();

		start_test("round_robin");
		for (int r = 0; r < rr_rounds; r++)
		begin
			pat_wr = req_vec_t'(rand_bits(num_ports));
			pat_rd = req_vec_t'(rand_bits(num_ports - 1)); // last read port stays idle
			align_round();
			@(posedge sys_clk);
			wr_req_addr <= pat_wr;
			rd_req_addr <= pat_rd;
			grants0 = grants_seen;
			@(negedge sys_clk);
			while (!(m_pos == last_pos && m_phase == mp_poll))
			begin
				if (any_grant)
					serve_hold(int'(rand_bits(2)), 1'b0);
				else
					@(negedge sys_clk);
			end
			@(posedge sys_clk);
			wr_req_addr <= '0;
			rd_req_addr <= '0;
			check_val("grant_count", $countones(pat_wr) + $countones(pat_rd),
				grants_seen - grants0);
		end
		end_test();

		start_test("back_pressure");
		for (int d = 0; d < 2; d++)
		begin
			k = port_id_t'(rand_bits(port_id_w));
			@(posedge sys_clk);
			if (d == 0)
				wr_req_addr[k] <= 1'b1;
			else
				rd_req_addr[k] <= 1'b1;
			wait_grant();
			serve_hold(4 + int'(rand_bits(3)), 1'b1); // other strobe first
			check_val("grant_after_done", '0, {wr_req_done, rd_req_done});
			@(posedge sys_clk);
			wr_req_addr <= '0;
			rd_req_addr <= '0;
		end
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
